/* design/axil_bus_bridge.sv */
`timescale 1ns/1ps

module axil_bus_bridge (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [pc_bus_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [pc_bus_pkg::AXI_DATA_W-1:0]   wdata,
   input  logic [pc_bus_pkg::AXI_DATA_W/8-1:0] wstrb,   // Ignored for the single byte lane
   input  logic                                wvalid,
   output logic                                wready,
   output pc_bus_pkg::axi_resp_e               bresp,
   output logic                                bvalid,
   input  logic                                bready,
   input  logic [pc_bus_pkg::AXI_ADDR_W-1:0]   araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic [pc_bus_pkg::AXI_DATA_W-1:0]   rdata,
   output pc_bus_pkg::axi_resp_e               rresp,
   output logic                                rvalid,
   input  logic                                rready,
   output logic                                req_start,
   output pc_bus_pkg::bus_status_e             req_status,
   output logic [pc_bus_pkg::AXI_ADDR_W-1:0]   req_addr,
   output logic [7:0]                          req_wdata,
   input  logic                                cyc_done,
   input  logic [7:0]                          cyc_rdata
);
   import pc_bus_pkg::*;

   typedef enum logic [1:0] {BR_IDLE, BR_BUSY, BR_RESP} br_state_e;

   br_state_e             state;
   logic                  is_wr;       // Direction of the pending transfer
   logic                  wr_acc;
   logic                  rd_acc;
   logic [AXI_ADDR_W-1:0] acc_addr;
   bus_status_e           dec_status;
   logic                  dec_err;
   axi_resp_e             resp_q;
   logic [7:0]            rdata_q;

   // Write needs both channels at once, so ready follows the pair
   assign awready  = (state == BR_IDLE) && (awvalid == wvalid);
   assign wready   = awready;
   assign arready  = (state == BR_IDLE) && !(awvalid && wvalid);   // Write wins a tie
   assign wr_acc   = awvalid && wvalid && awready;
   assign rd_acc   = arvalid && arready;
   assign acc_addr = wr_acc ? awaddr : araddr;

   // Region from address bits 15:14
   always_comb begin
      dec_status = STAT_PASSIVE;
      dec_err    = 1'b0;
      case (acc_addr[AXI_ADDR_W-1 -: 2])
         2'b00: dec_status = wr_acc ? STAT_MEM_WR : STAT_MEM_RD;
         2'b01: dec_status = wr_acc ? STAT_IO_WR : STAT_IO_RD;
         2'b10: begin
            if (wr_acc) begin
               dec_err = 1'b1;   // INTA space is read only
            end else begin
               dec_status = STAT_INTA;
            end
         end
         default: dec_err = 1'b1;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= BR_IDLE;
         req_start <= 1'b0;
         is_wr     <= 1'b0;
      end else begin
         req_start <= 1'b0;
         case (state)
            BR_IDLE: begin
               if (wr_acc || rd_acc) begin
                  is_wr <= wr_acc;
                  if (dec_err) begin
                     state <= BR_RESP;   // No bus cycle for a bad access
                  end else begin
                     req_start <= 1'b1;
                     state     <= BR_BUSY;
                  end
               end
            end
            BR_BUSY: begin
               if (cyc_done) begin
                  state <= BR_RESP;
               end
            end
            BR_RESP: begin
               if ((bvalid && bready) || (rvalid && rready)) begin
                  state <= BR_IDLE;
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_acc || rd_acc) begin
         req_status <= dec_status;
         req_addr   <= acc_addr;
         req_wdata  <= wdata[7:0];
         resp_q     <= dec_err ? RESP_SLVERR : RESP_OKAY;
         rdata_q    <= 8'h00;
      end else if ((state == BR_BUSY) && cyc_done && !is_wr) begin
         rdata_q <= cyc_rdata;
      end
   end

   assign bvalid = (state == BR_RESP) && is_wr;
   assign rvalid = (state == BR_RESP) && !is_wr;
   assign bresp  = resp_q;
   assign rresp  = resp_q;
   assign rdata  = {{(AXI_DATA_W-8){1'b0}}, rdata_q};

   a_one_resp: assert property (@(posedge clk) disable iff (rst) !(bvalid && rvalid))
      else $error("bvalid and rvalid high together");

endmodule

/* design/bus_controller.sv */
`timescale 1ns/1ps

module bus_controller (
   input  logic                    clk,
   input  logic                    rst,
   input  pc_bus_pkg::bus_status_e s_n,
   input  logic                    aen_n,
   output logic                    ale,
   output logic                    dtr,
   output logic                    den,
   output logic                    mrdc_n,
   output logic                    amwc_n,
   output logic                    iorc_n,
   output logic                    aiowc_n,
   output logic                    inta_n
);
   import pc_bus_pkg::*;

   ctl_state_e state;
   ctl_state_e state_nxt;
   logic       mrdc;   // Latched command decode
   logic       amwc;
   logic       iorc;
   logic       aiowc;
   logic       inta;
   logic       activate;
   logic       cmd_phase;
   logic       rd_cycle;
   logic       wr_cycle;

   assign activate  = (s_n != STAT_PASSIVE);
   assign ale       = (state == CTL_IDLE) && !aen_n && activate;   // DMA holds off the cycle
   assign cmd_phase = (state == CTL_T1) || (state == CTL_T2);
   assign rd_cycle  = mrdc || iorc || inta;
   assign wr_cycle  = amwc || aiowc;

   always_comb begin
      case (state)
         CTL_IDLE: state_nxt = ale ? CTL_T1 : CTL_IDLE;
         CTL_T1:   state_nxt = CTL_T2;
         CTL_T2:   state_nxt = CTL_T3;
         default:  state_nxt = CTL_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= CTL_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Decode tracks the status while idle and freezes once the cycle runs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mrdc  <= 1'b0;
         amwc  <= 1'b0;
         iorc  <= 1'b0;
         aiowc <= 1'b0;
         inta  <= 1'b0;
      end else if (state == CTL_IDLE) begin
         mrdc  <= (s_n == STAT_MEM_RD);
         amwc  <= (s_n == STAT_MEM_WR);
         iorc  <= (s_n == STAT_IO_RD);
         aiowc <= (s_n == STAT_IO_WR);
         inta  <= (s_n == STAT_INTA);
      end
   end

   // Strobes low through T1 and T2
   assign mrdc_n  = !(cmd_phase && mrdc);
   assign amwc_n  = !(cmd_phase && amwc);
   assign iorc_n  = !(cmd_phase && iorc);
   assign aiowc_n = !(cmd_phase && aiowc);
   assign inta_n  = !(cmd_phase && inta);

   // Transceiver control
   assign dtr = !((state != CTL_IDLE) && rd_cycle);
   assign den = ((state == CTL_T2) && rd_cycle) || ((state != CTL_IDLE) && wr_cycle);

   a_one_cmd: assert property (@(posedge clk) disable iff (rst)
      $onehot0({!mrdc_n, !amwc_n, !iorc_n, !aiowc_n, !inta_n}))
      else $error("more than one command strobe active");

endmodule

/* design/bus_cycle_sequencer.sv */
`timescale 1ns/1ps

module bus_cycle_sequencer (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              req_start,
   input  pc_bus_pkg::bus_status_e           req_status,
   input  logic [pc_bus_pkg::BUS_ADDR_W-1:0] req_addr,
   input  logic [7:0]                        req_wdata,
   output logic                              cyc_done,
   output logic [7:0]                        cyc_rdata,
   output pc_bus_pkg::bus_status_e           s_n,
   output logic [pc_bus_pkg::BUS_ADDR_W-1:0] bus_addr,
   output logic [7:0]                        bus_wdata,
   input  logic                              ale,
   input  logic [7:0]                        bus_rdata
);
   import pc_bus_pkg::*;

   typedef enum logic [1:0] {SEQ_IDLE, SEQ_WAIT, SEQ_RUN, SEQ_DONE} seq_state_e;

   seq_state_e state;
   logic       t2;   // Second strobe state of the cycle

   // Status is held until the controller answers with ALE
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= SEQ_IDLE;
         s_n   <= STAT_PASSIVE;
         t2    <= 1'b0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (req_start) begin
                  s_n   <= req_status;
                  state <= SEQ_WAIT;
               end
            end
            SEQ_WAIT: begin
               if (ale) begin
                  s_n   <= STAT_PASSIVE;   // Passive from T1 on
                  t2    <= 1'b0;
                  state <= SEQ_RUN;
               end
            end
            SEQ_RUN: begin
               t2 <= 1'b1;
               if (t2) begin
                  state <= SEQ_DONE;
               end
            end
            default: state <= SEQ_IDLE;   // T3 closes the cycle
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == SEQ_IDLE) && req_start) begin
         bus_addr  <= req_addr;
         bus_wdata <= req_wdata;
      end
      if ((state == SEQ_RUN) && t2) begin
         cyc_rdata <= bus_rdata;   // Sampled at the end of T2
      end
   end

   assign cyc_done = (state == SEQ_DONE);

   a_idle_passive: assert property (@(posedge clk) disable iff (rst)
      (state == SEQ_IDLE) |-> (s_n == STAT_PASSIVE))
      else $error("status driven while sequencer idle");

endmodule

/* design/local_bus_target.sv */
`timescale 1ns/1ps

module local_bus_target (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              ale,
   input  logic [pc_bus_pkg::BUS_ADDR_W-1:0] bus_addr,
   input  logic [7:0]                        bus_wdata,
   output logic [7:0]                        bus_rdata,
   input  logic                              den,
   input  logic                              dtr,
   input  logic                              mrdc_n,
   input  logic                              amwc_n,
   input  logic                              iorc_n,
   input  logic                              aiowc_n,
   input  logic                              inta_n
);
   import pc_bus_pkg::*;

   logic [7:0]                   mem [MEM_DEPTH];
   logic [7:0]                   io_regs [IO_REGS];
   logic [BUS_ADDR_W-1:0]        addr_q;   // Address latch, 8282 style
   logic [$clog2(MEM_DEPTH)-1:0] mem_idx;
   logic [$clog2(IO_REGS)-1:0]   io_idx;
   logic                         wr_en;
   logic                         rd_en;
   logic [7:0]                   rd_sel;

   always_ff @(posedge clk) begin
      if (ale) begin
         addr_q <= bus_addr;
      end
   end

   assign mem_idx = addr_q[$clog2(MEM_DEPTH)-1:0];
   assign io_idx  = addr_q[$clog2(IO_REGS)-1:0];
   assign wr_en   = den && dtr;    // Transceiver toward the target
   assign rd_en   = den && !dtr;   // Transceiver toward the processor

   always_ff @(posedge clk) begin
      if (wr_en && !amwc_n) begin
         mem[mem_idx] <= bus_wdata;
      end
   end

   // I/O registers come up cleared
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < IO_REGS; i++) begin
            io_regs[i] <= 8'h00;
         end
      end else if (wr_en && !aiowc_n) begin
         io_regs[io_idx] <= bus_wdata;
      end
   end

   always_comb begin
      rd_sel = 8'h00;
      if (!mrdc_n) begin
         rd_sel = mem[mem_idx];
      end else if (!iorc_n) begin
         rd_sel = io_regs[io_idx];
      end else if (!inta_n) begin
         rd_sel = io_regs[VECTOR_REG];   // Interrupt vector byte
      end
   end

   assign bus_rdata = rd_en ? rd_sel : 8'h00;

endmodule

/* design/pc_bus_pkg.sv */
package pc_bus_pkg;

   // AXI4-Lite port widths
   localparam int AXI_ADDR_W = 16;
   localparam int AXI_DATA_W = 32;

   // Local bus address width
   localparam int BUS_ADDR_W = 16;

   // Target storage
   localparam int MEM_DEPTH  = 256;   // Bytes, low 8 address bits
   localparam int IO_REGS    = 16;    // Registers, low 4 address bits
   localparam int VECTOR_REG = 15;    // I/O register returned on INTA

   // 8088 status codes as seen on S2..S0
   typedef enum logic [2:0] {
      STAT_INTA    = 3'b000,
      STAT_IO_RD   = 3'b001,
      STAT_IO_WR   = 3'b010,
      STAT_MEM_RD  = 3'b101,
      STAT_MEM_WR  = 3'b110,
      STAT_PASSIVE = 3'b111
   } bus_status_e;

   // 8288 controller T-states
   typedef enum logic [1:0] {
      CTL_IDLE = 2'b00,
      CTL_T1   = 2'b01,
      CTL_T2   = 2'b10,
      CTL_T3   = 2'b11
   } ctl_state_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

endpackage

/* design/pc_bus_top.sv */
`timescale 1ns/1ps

module pc_bus_top (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                aen_n,
   input  logic [pc_bus_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [pc_bus_pkg::AXI_DATA_W-1:0]   wdata,
   input  logic [pc_bus_pkg::AXI_DATA_W/8-1:0] wstrb,
   input  logic                                wvalid,
   output logic                                wready,
   output pc_bus_pkg::axi_resp_e               bresp,
   output logic                                bvalid,
   input  logic                                bready,
   input  logic [pc_bus_pkg::AXI_ADDR_W-1:0]   araddr,
   input  logic                                arvalid,
   output logic                                arready,
   output logic [pc_bus_pkg::AXI_DATA_W-1:0]   rdata,
   output pc_bus_pkg::axi_resp_e               rresp,
   output logic                                rvalid,
   input  logic                                rready,
   output logic                                ale,
   output logic                                dtr,
   output logic                                den,
   output logic                                mrdc_n,
   output logic                                amwc_n,
   output logic                                iorc_n,
   output logic                                aiowc_n,
   output logic                                inta_n
);
   import pc_bus_pkg::*;

   // Bridge to sequencer
   logic                  req_start;
   bus_status_e           req_status;
   logic [AXI_ADDR_W-1:0] req_addr;
   logic [7:0]            req_wdata;
   logic                  cyc_done;
   logic [7:0]            cyc_rdata;

   // Local bus
   bus_status_e           s_n;
   logic [BUS_ADDR_W-1:0] bus_addr;
   logic [7:0]            bus_wdata;
   logic [7:0]            bus_rdata;

   axil_bus_bridge u_bridge (
      .clk        (clk),
      .rst        (rst),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .req_start  (req_start),
      .req_status (req_status),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .cyc_done   (cyc_done),
      .cyc_rdata  (cyc_rdata)
   );

   bus_cycle_sequencer u_seq (
      .clk        (clk),
      .rst        (rst),
      .req_start  (req_start),
      .req_status (req_status),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .cyc_done   (cyc_done),
      .cyc_rdata  (cyc_rdata),
      .s_n        (s_n),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .ale        (ale),
      .bus_rdata  (bus_rdata)
   );

   bus_controller u_ctl (
      .clk     (clk),
      .rst     (rst),
      .s_n     (s_n),
      .aen_n   (aen_n),
      .ale     (ale),
      .dtr     (dtr),
      .den     (den),
      .mrdc_n  (mrdc_n),
      .amwc_n  (amwc_n),
      .iorc_n  (iorc_n),
      .aiowc_n (aiowc_n),
      .inta_n  (inta_n)
   );

   local_bus_target u_target (
      .clk       (clk),
      .rst       (rst),
      .ale       (ale),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_rdata (bus_rdata),
      .den       (den),
      .dtr       (dtr),
      .mrdc_n    (mrdc_n),
      .amwc_n    (amwc_n),
      .iorc_n    (iorc_n),
      .aiowc_n   (aiowc_n),
      .inta_n    (inta_n)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, run from the project root

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=pc_bus_sim

verilator --binary --timing --assert -f src.f --top-module pc_bus_tb \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/pc_bus_tb.sv */
`timescale 1ns/1ps

module pc_bus_tb;
   import pc_bus_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 64 + 200;
   localparam int HOLD_CYCLES     = 12;   // aen_n high this long

   logic                    clk;
   logic                    rst;
   logic                    aen_n;
   logic [AXI_ADDR_W-1:0]   awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [AXI_DATA_W-1:0]   wdata;
   logic [AXI_DATA_W/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   axi_resp_e               bresp;
   logic                    bvalid;
   logic                    bready;
   logic [AXI_ADDR_W-1:0]   araddr;
   logic                    arvalid;
   logic                    arready;
   logic [AXI_DATA_W-1:0]   rdata;
   axi_resp_e               rresp;
   logic                    rvalid;
   logic                    rready;
   logic                    ale;
   logic                    dtr;
   logic                    den;
   logic                    mrdc_n;
   logic                    amwc_n;
   logic                    iorc_n;
   logic                    aiowc_n;
   logic                    inta_n;

   int         errors;
   int         checks;
   int         cnt_ale;      // Running totals from the bus monitor
   int         cnt_low [5];  // mrdc, amwc, iorc, aiowc, inta
   int         ale_mark;
   int         low_mark [5];
   logic [7:0] mem_model [MEM_DEPTH];
   logic [7:0] io_model [IO_REGS];

   pc_bus_top UUT (
      .clk(clk), .rst(rst), .aen_n(aen_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bresp(bresp), .bvalid(bvalid), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .ale(ale), .dtr(dtr), .den(den), .mrdc_n(mrdc_n), .amwc_n(amwc_n),
      .iorc_n(iorc_n), .aiowc_n(aiowc_n), .inta_n(inta_n)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Counts ALE pulses and low strobe cycles at each rising edge
   always @(posedge clk) begin
      if (ale) cnt_ale <= cnt_ale + 1;
      if (!mrdc_n) cnt_low[0] <= cnt_low[0] + 1;
      if (!amwc_n) cnt_low[1] <= cnt_low[1] + 1;
      if (!iorc_n) cnt_low[2] <= cnt_low[2] + 1;
      if (!aiowc_n) cnt_low[3] <= cnt_low[3] + 1;
      if (!inta_n) cnt_low[4] <= cnt_low[4] + 1;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, a transfer never finished", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s = %s, expected %s", $time, name, got.name(), exp.name());
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   function automatic string strobe_name(input int i);
      case (i)
         0:       return "mrdc_n";
         1:       return "amwc_n";
         2:       return "iorc_n";
         3:       return "aiowc_n";
         default: return "inta_n";
      endcase
   endfunction

   // Strobe the address map calls for or -1 for a refused access
   function automatic int strobe_for(input logic [15:0] addr, input logic wr);
      case (addr[15:14])
         2'b00:   return wr ? 1 : 0;
         2'b01:   return wr ? 3 : 2;
         2'b10:   return wr ? -1 : 4;
         default: return -1;
      endcase
   endfunction

   task automatic mark_counts;
      ale_mark = cnt_ale;
      for (int i = 0; i < 5; i++) low_mark[i] = cnt_low[i];
   endtask

   // One ALE and two strobe cycles for a legal access and none for a refused one
   task automatic check_cycle(input int idx);
      check_count("ale pulses", cnt_ale - ale_mark, (idx >= 0) ? 1 : 0);
      for (int i = 0; i < 5; i++) begin
         check_count({strobe_name(i), " low cycles"}, cnt_low[i] - low_mark[i],
                     (i == idx) ? 2 : 0);
      end
   endtask

   task automatic send_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge clk);
      awaddr  = addr;
      wdata   = {24'h0, data};
      wstrb   = 4'h1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      #1;
      while (!(awready && wready)) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);   // Taken at the edge just passed
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic finish_write(input logic [15:0] addr, input logic [7:0] data, input int hold);
      int        idx;
      axi_resp_e first;
      idx = strobe_for(addr, 1'b1);
      while (!bvalid) @(negedge clk);
      first = bresp;
      repeat (hold) begin
         @(negedge clk);
         check_bit("bvalid", bvalid, 1'b1);
         check_resp("bresp", bresp, first);
         check_bit("awready", awready, 1'b0);
      end
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      check_resp("bresp", first, (idx < 0) ? RESP_SLVERR : RESP_OKAY);
      check_cycle(idx);
      if (idx == 1) mem_model[addr[7:0]] = data;
      if (idx == 3) io_model[addr[3:0]] = data;
   endtask

   task automatic axil_write(input logic [15:0] addr, input logic [7:0] data);
      mark_counts();
      send_write(addr, data);
      finish_write(addr, data, 0);
   endtask

   task automatic axil_read(input logic [15:0] addr);
      int         idx;
      logic [7:0] exp;
      axi_resp_e  resp;
      logic [7:0] data;
      idx = strobe_for(addr, 1'b0);
      case (idx)
         0:       exp = mem_model[addr[7:0]];
         2:       exp = io_model[addr[3:0]];
         4:       exp = io_model[VECTOR_REG];
         default: exp = 8'h00;
      endcase
      mark_counts();
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      #1;
      while (!arready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      resp = rresp;
      data = rdata[7:0];
      check_bit("rdata[31:8] nonzero", |rdata[31:8], 1'b0);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
      check_resp("rresp", resp, (idx < 0) ? RESP_SLVERR : RESP_OKAY);
      check_byte("rdata", data, exp);
      check_cycle(idx);
   endtask

   task automatic reset_values;
      @(negedge clk);
      check_bit("ale", ale, 1'b0);
      check_bit("den", den, 1'b0);
      check_bit("dtr", dtr, 1'b1);
      check_bit("mrdc_n", mrdc_n, 1'b1);
      check_bit("amwc_n", amwc_n, 1'b1);
      check_bit("iorc_n", iorc_n, 1'b1);
      check_bit("aiowc_n", aiowc_n, 1'b1);
      check_bit("inta_n", inta_n, 1'b1);
      check_bit("bvalid", bvalid, 1'b0);
      check_bit("rvalid", rvalid, 1'b0);
      check_bit("awready", awready, 1'b1);
      check_bit("wready", wready, 1'b1);
      check_bit("arready", arready, 1'b1);
   endtask

   task automatic mem_round_trip;
      logic [15:0] addrs [4];
      for (int i = 0; i < 4; i++) begin
         addrs[i] = {2'b00, 14'($urandom())};
         axil_write(addrs[i], 8'($urandom()));
      end
      for (int i = 0; i < 4; i++) axil_read(addrs[i]);
   endtask

   // Same offset in memory and I/O space written in both orders
   task automatic separate_spaces;
      logic [3:0] k;
      logic [7:0] a;
      k = 4'($urandom());
      a = 8'($urandom());
      axil_write({2'b00, 10'h0, k}, a);
      axil_write({2'b01, 10'h0, k}, ~a);
      axil_read({2'b00, 10'h0, k});
      axil_read({2'b01, 10'h0, k});
      k = k + 4'd1;
      a = 8'($urandom());
      axil_write({2'b01, 10'h0, k}, a);
      axil_write({2'b00, 10'h0, k}, ~a);
      axil_read({2'b01, 10'h0, k});
      axil_read({2'b00, 10'h0, k});
   endtask

   task automatic inta_vector;
      axil_write({2'b01, 14'(VECTOR_REG)}, 8'($urandom()));
      axil_read({2'b10, 14'($urandom())});
   endtask

   task automatic error_responses;
      axil_write({2'b10, 14'($urandom())}, 8'($urandom()));
      axil_read({2'b11, 14'($urandom())});
      axil_write({2'b11, 14'($urandom())}, 8'($urandom()));
   endtask

   task automatic hold_and_back_pressure;
      logic [15:0] addr_a;
      logic [15:0] addr_b;
      logic [7:0]  data;
      addr_a = {2'b01, 10'h0, 4'($urandom())};
      data   = 8'($urandom());
      @(negedge clk);
      aen_n = 1'b1;   // DMA owns the bus
      mark_counts();
      send_write(addr_a, data);
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         check_bit("bvalid", bvalid, 1'b0);
      end
      check_count("ale pulses while aen_n high", cnt_ale - ale_mark, 0);
      aen_n = 1'b0;
      finish_write(addr_a, data, 0);
      axil_read(addr_a);
      addr_a = {2'b00, 14'($urandom())};
      addr_b = addr_a ^ 16'h0001;
      axil_write(addr_b, ~data);
      mark_counts();
      send_write(addr_a, data);
      awaddr  = addr_b;   // Second write waits behind the held response
      wdata   = {24'h0, data};
      awvalid = 1'b1;
      wvalid  = 1'b1;
      finish_write(addr_a, data, 6);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      axil_read(addr_a);
      axil_read(addr_b);
   endtask

   initial begin
      void'($urandom(32'h6ae6_908f));
      errors  = 0;
      checks  = 0;
      rst     = 1'b1;
      aen_n   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      for (int i = 0; i < IO_REGS; i++) io_model[i] = 8'h00;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      reset_values();
      mem_round_trip();
      separate_spaces();
      inta_vector();
      error_responses();
      hold_and_back_pressure();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* src.f */
design/pc_bus_pkg.sv
design/axil_bus_bridge.sv
design/bus_cycle_sequencer.sv
design/bus_controller.sv
design/local_bus_target.sv
design/pc_bus_top.sv
sim/pc_bus_tb.sv
